// File: hw/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address width in bits
`define ICACHE_ADDR_W 32

// direct-mapped store geometry
`define ICACHE_LINES 32
`define ICACHE_LINE_BYTES 8 // two instruction words per line

// outstanding block requests
`define ICACHE_SLOTS 4

// blocks fetched ahead of the current block
`define ICACHE_PREFETCH_DEPTH 7

// fully associative victim buffer
`define ICACHE_VICTIM_WAYS 2

`endif

// File: hw/icache_addr_pkg.sv
package icache_addr_pkg;

    `include "icache_consts.svh"

    // direct-mapped decode of a fetch address
    typedef struct packed {
        logic [`ICACHE_ADDR_W-17:0] upper;
        logic [7:0]                 tag;
        logic [4:0]                 index;
        logic                       word_sel; // upper or lower word of the line
        logic [1:0]                 byte_off;
    } line_view_t;

    // victim decode, tag is line tag joined to index
    typedef struct packed {
        logic [`ICACHE_ADDR_W-17:0] upper;
        logic [12:0]                tag;
        logic [2:0]                 offset;
    } victim_view_t;

    typedef union packed {
        line_view_t   line;
        victim_view_t victim;
    } fetch_addr_u;

    typedef struct packed {
        logic        valid;
        logic [7:0]  tag;
        logic [63:0] data;
    } icache_line_t;

    typedef struct packed {
        logic        valid;
        logic [12:0] tag;
        logic [63:0] data;
    } victim_line_t;

endpackage

// File: hw/mem_bus_pkg.sv
package mem_bus_pkg;

    // command toward memory, only loads in an instruction cache
    typedef enum logic [1:0] {
        BUS_NONE = 2'b00,
        BUS_LOAD = 2'b01
    } bus_command_e;

    // transaction tag handed out by memory
    // zero means no tag, on both the response and the data return
    typedef logic [3:0] mem_tag_t;

endpackage

// File: hw/miss_slot_if.sv
`timescale 1ns/10ps

interface miss_slot_if
    import icache_addr_pkg::*, mem_bus_pkg::*;
();

    logic        alloc;         // strobe, take alloc_addr
    fetch_addr_u alloc_addr;
    logic        flush;         // strobe, drop the request
    logic        busy;
    logic        waiting_issue;
    logic        waiting_data;
    fetch_addr_u slot_addr;
    logic        issued;        // strobe, memory accepted with issued_tag
    mem_tag_t    issued_tag;
    mem_tag_t    fill_tag;      // returning tag, same on every slot
    logic        filled;        // strobe, fill_tag matched this slot

    modport ctrl (output alloc, alloc_addr, flush, input busy);

    modport port (
        input  waiting_issue, waiting_data, slot_addr, filled,
        output issued, issued_tag, fill_tag
    );

    modport slot (
        input  alloc, alloc_addr, flush, issued, issued_tag, fill_tag,
        output busy, waiting_issue, waiting_data, slot_addr, filled
    );

endinterface

// File: hw/prefetch_ctrl.sv
`timescale 1ns/10ps

module prefetch_ctrl
    import icache_addr_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic [`ICACHE_ADDR_W-1:0] proc_addr,
    input  logic                      proc_hit,
    output fetch_addr_u               probe_addr,
    input  logic                      probe_hit,
    input  logic                      probe_victim_hit,
    output logic                      swap_we,
    output fetch_addr_u               swap_addr,
    miss_slot_if.ctrl                 slots [`ICACHE_SLOTS]
);

    localparam int unsigned AW = `ICACHE_ADDR_W;
    localparam int unsigned PW = $clog2(`ICACHE_SLOTS);
    localparam logic [AW-1:0] BLOCK_MASK = ~AW'(`ICACHE_LINE_BYTES - 1);
    localparam logic [AW-1:0] STEP = AW'(`ICACHE_LINE_BYTES);
    localparam logic [AW-1:0] SPAN = AW'(`ICACHE_PREFETCH_DEPTH * `ICACHE_LINE_BYTES);

    logic [AW-1:0]            last_addr;
    logic [AW-1:0]            pf_addr;    // next block to probe
    logic [AW-1:0]            cur_block;
    logic [AW-1:0]            goal;
    logic [PW-1:0]            tail_ptr;
    logic [PW-1:0]            tail_eff;
    logic [`ICACHE_SLOTS-1:0] busy_v;
    logic                     redirect;
    logic                     walk;
    logic                     pf_hit;
    logic                     do_alloc;

    assign cur_block = proc_addr & BLOCK_MASK;
    assign goal      = cur_block + SPAN;

    // anything but holding or stepping one word is a jump
    assign redirect = (proc_addr != last_addr) && (proc_addr != last_addr + AW'(4));

    assign walk   = !redirect && (pf_addr <= goal);
    assign pf_hit = probe_hit || probe_victim_hit;

    // pool drained, so allocation restarts at slot 0 like the issue pointer
    assign tail_eff = (busy_v == '0) ? '0 : tail_ptr;
    assign do_alloc = walk && !pf_hit && !busy_v[tail_eff];

    assign probe_addr = pf_addr;
    assign swap_addr  = pf_addr;
    assign swap_we    = walk && probe_victim_hit && !probe_hit; // pull block back into the array

    for (genvar g = 0; g < `ICACHE_SLOTS; g++) begin : g_slot
        assign busy_v[g]           = slots[g].busy;
        assign slots[g].alloc      = do_alloc && (tail_eff == PW'(g));
        assign slots[g].alloc_addr = pf_addr;
        assign slots[g].flush      = redirect;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_addr <= '0;
            pf_addr   <= '0;
            tail_ptr  <= '0;
        end else begin
            last_addr <= proc_addr;
            if (redirect) begin
                // skip the new block if it is already there
                pf_addr  <= proc_hit ? cur_block + STEP : cur_block;
                tail_ptr <= '0;
            end else if (walk && (pf_hit || do_alloc)) begin
                pf_addr <= pf_addr + STEP;
                if (do_alloc) begin
                    tail_ptr <= (tail_eff == PW'(`ICACHE_SLOTS - 1)) ? '0 : tail_eff + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/miss_slot.sv
`timescale 1ns/10ps

module miss_slot
    import icache_addr_pkg::*, mem_bus_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    miss_slot_if.slot slot
);

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_WAIT_ISSUE,
        SLOT_WAIT_DATA
    } slot_state_e;

    slot_state_e state;
    fetch_addr_u addr;
    mem_tag_t    tag;    // valid only while waiting for data

    assign slot.busy          = (state != SLOT_IDLE);
    assign slot.waiting_issue = (state == SLOT_WAIT_ISSUE);
    assign slot.waiting_data  = (state == SLOT_WAIT_DATA);
    assign slot.slot_addr     = addr;

    // a flushed slot no longer owns its tag
    assign slot.filled = (state == SLOT_WAIT_DATA) && (slot.fill_tag != '0)
                         && (slot.fill_tag == tag) && !slot.flush;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= SLOT_IDLE;
        end else if (slot.flush) begin
            state <= SLOT_IDLE;
        end else begin
            case (state)
                SLOT_IDLE:       if (slot.alloc) state <= SLOT_WAIT_ISSUE;
                SLOT_WAIT_ISSUE: if (slot.issued) state <= SLOT_WAIT_DATA;
                SLOT_WAIT_DATA:  if (slot.filled) state <= SLOT_IDLE;
                default:         state <= SLOT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (slot.alloc && (state == SLOT_IDLE)) begin
            addr <= slot.alloc_addr;
        end
        if (slot.issued) begin
            tag <= slot.issued_tag;
        end
    end

endmodule

// File: hw/mem_port.sv
`timescale 1ns/10ps

module mem_port
    import icache_addr_pkg::*, mem_bus_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  mem_tag_t                  mem_response,
    input  logic                      mem_response_valid,
    input  mem_tag_t                  mem_tag,
    input  logic [63:0]               mem_data,
    output bus_command_e              mem_command,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr,
    output logic                      fill_we,
    output fetch_addr_u               fill_addr,
    output logic [63:0]               fill_data,
    miss_slot_if.port                 slots [`ICACHE_SLOTS]
);

    localparam int unsigned PW = $clog2(`ICACHE_SLOTS);

    logic [PW-1:0]            issue_ptr;
    logic [`ICACHE_SLOTS-1:0] wait_issue_v;
    logic [`ICACHE_SLOTS-1:0] wait_data_v;
    logic [`ICACHE_SLOTS-1:0] filled_v;
    fetch_addr_u              slot_addr_v [`ICACHE_SLOTS];
    logic                     all_idle;
    logic                     accept;

    for (genvar g = 0; g < `ICACHE_SLOTS; g++) begin : g_slot
        assign wait_issue_v[g]     = slots[g].waiting_issue;
        assign wait_data_v[g]      = slots[g].waiting_data;
        assign filled_v[g]         = slots[g].filled;
        assign slot_addr_v[g]      = slots[g].slot_addr;
        assign slots[g].issued     = accept && (issue_ptr == PW'(g));
        assign slots[g].issued_tag = mem_response;
        assign slots[g].fill_tag   = mem_tag; // every slot compares the same tag
    end

    // true right after a flush, and whenever the pool has drained
    assign all_idle = ((wait_issue_v | wait_data_v) == '0);

    assign mem_command = wait_issue_v[issue_ptr] ? BUS_LOAD : BUS_NONE;
    assign mem_addr    = slot_addr_v[issue_ptr];
    assign accept      = (mem_command == BUS_LOAD) && mem_response_valid && (mem_response != '0);

    always_ff @(posedge clock) begin
        if (reset || all_idle) begin
            issue_ptr <= '0;
        end else if (accept) begin
            issue_ptr <= (issue_ptr == PW'(`ICACHE_SLOTS - 1)) ? '0 : issue_ptr + 1'b1;
        end
    end

    // at most one slot holds a given tag
    always_comb begin
        fill_we   = 1'b0;
        fill_addr = slot_addr_v[0];
        for (int i = 0; i < `ICACHE_SLOTS; i++) begin
            if (filled_v[i]) begin
                fill_we   = 1'b1;
                fill_addr = slot_addr_v[i];
            end
        end
    end

    assign fill_data = mem_data;

endmodule

// File: hw/icache_store.sv
`timescale 1ns/10ps

module icache_store
    import icache_addr_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  fetch_addr_u proc_addr,
    output logic [31:0] proc_data,
    output logic        proc_valid,
    input  fetch_addr_u probe_addr,
    output logic        probe_hit,
    output logic        probe_victim_hit,
    input  logic        fill_we,
    input  fetch_addr_u fill_addr,
    input  logic [63:0] fill_data,
    input  logic        swap_we,
    input  fetch_addr_u swap_addr
);

    localparam int unsigned VW = $clog2(`ICACHE_VICTIM_WAYS);

    icache_line_t   lines [`ICACHE_LINES];
    victim_line_t   victims [`ICACHE_VICTIM_WAYS];
    logic [VW-1:0]  lru;       // victim way replaced on the next eviction

    // lookup ports: 0 processor, 1 prefetch probe, 2 swap
    fetch_addr_u    look_addr [3];
    logic           line_hit [3];
    logic           vic_hit [3];
    logic [VW-1:0]  vic_way [3];

    logic [4:0]     fill_idx;
    logic [4:0]     swap_idx;
    logic           swap_do;
    icache_line_t   proc_line;
    victim_line_t   proc_victim;

    assign look_addr[0] = proc_addr;
    assign look_addr[1] = probe_addr;
    assign look_addr[2] = swap_addr;

    // same word read both ways: index and tag for the array, wide tag for the victims
    for (genvar p = 0; p < 3; p++) begin : g_lookup
        always_comb begin
            line_hit[p] = lines[look_addr[p].line.index].valid
                          && (lines[look_addr[p].line.index].tag == look_addr[p].line.tag);
            vic_hit[p] = 1'b0;
            vic_way[p] = '0;
            for (int w = 0; w < `ICACHE_VICTIM_WAYS; w++) begin
                if (victims[w].valid && (victims[w].tag == look_addr[p].victim.tag)) begin
                    vic_hit[p] = 1'b1;
                    vic_way[p] = VW'(w);
                end
            end
        end
    end

    assign proc_line   = lines[proc_addr.line.index];
    assign proc_victim = victims[vic_way[0]];

    always_comb begin
        if (vic_hit[0]) begin
            proc_data = proc_addr.line.word_sel ? proc_victim.data[63:32] : proc_victim.data[31:0];
        end else begin
            proc_data = proc_addr.line.word_sel ? proc_line.data[63:32] : proc_line.data[31:0];
        end
    end

    assign proc_valid       = line_hit[0] || vic_hit[0];
    assign probe_hit        = line_hit[1];
    assign probe_victim_hit = vic_hit[1];

    assign fill_idx = fill_addr.line.index;
    assign swap_idx = swap_addr.line.index;
    assign swap_do  = swap_we && vic_hit[2] && !line_hit[2] && !fill_we; // fill has priority

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ICACHE_LINES; i++) begin
                lines[i].valid <= 1'b0;
            end
            for (int w = 0; w < `ICACHE_VICTIM_WAYS; w++) begin
                victims[w].valid <= 1'b0;
            end
            lru <= '0;
        end else if (fill_we) begin
            lines[fill_idx] <= '{valid: 1'b1, tag: fill_addr.line.tag, data: fill_data};
            if (lines[fill_idx].valid) begin
                // evicted line keeps its index in the wide tag
                victims[lru] <= '{valid: 1'b1,
                                  tag:   {lines[fill_idx].tag, fill_idx},
                                  data:  lines[fill_idx].data};
                lru <= lru + 1'b1;
            end
        end else if (swap_do) begin
            lines[swap_idx] <= '{valid: victims[vic_way[2]].valid,
                                 tag:   victims[vic_way[2]].tag[12:5],
                                 data:  victims[vic_way[2]].data};
            victims[vic_way[2]] <= '{valid: lines[swap_idx].valid,
                                     tag:   {lines[swap_idx].tag, swap_idx},
                                     data:  lines[swap_idx].data};
            lru <= vic_way[2] + 1'b1; // swapped way is now most recent
        end
    end

endmodule

// File: hw/icache_top.sv
`timescale 1ns/10ps

module icache_top
    import icache_addr_pkg::*, mem_bus_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic [`ICACHE_ADDR_W-1:0] proc_addr,
    input  mem_tag_t                  mem_response,
    input  logic                      mem_response_valid,
    input  mem_tag_t                  mem_tag,
    input  logic [63:0]               mem_data,
    output logic [31:0]               proc_data,
    output logic                      proc_valid,
    output bus_command_e              mem_command,
    output logic [`ICACHE_ADDR_W-1:0] mem_addr
);

    fetch_addr_u probe_addr;
    logic        probe_hit;
    logic        probe_victim_hit;
    logic        swap_we;
    fetch_addr_u swap_addr;
    logic        fill_we;
    fetch_addr_u fill_addr;
    logic [63:0] fill_data;

    miss_slot_if slot_bus [`ICACHE_SLOTS] ();

    prefetch_ctrl u_prefetch_ctrl (
        .clock            (clock),
        .reset            (reset),
        .proc_addr        (proc_addr),
        .proc_hit         (proc_valid),
        .probe_addr       (probe_addr),
        .probe_hit        (probe_hit),
        .probe_victim_hit (probe_victim_hit),
        .swap_we          (swap_we),
        .swap_addr        (swap_addr),
        .slots            (slot_bus)
    );

    for (genvar g = 0; g < `ICACHE_SLOTS; g++) begin : g_slot
        miss_slot u_miss_slot (
            .clock (clock),
            .reset (reset),
            .slot  (slot_bus[g])
        );
    end

    mem_port u_mem_port (
        .clock              (clock),
        .reset              (reset),
        .mem_response       (mem_response),
        .mem_response_valid (mem_response_valid),
        .mem_tag            (mem_tag),
        .mem_data           (mem_data),
        .mem_command        (mem_command),
        .mem_addr           (mem_addr),
        .fill_we            (fill_we),
        .fill_addr          (fill_addr),
        .fill_data          (fill_data),
        .slots              (slot_bus)
    );

    icache_store u_icache_store (
        .clock            (clock),
        .reset            (reset),
        .proc_addr        (proc_addr),
        .proc_data        (proc_data),
        .proc_valid       (proc_valid),
        .probe_addr       (probe_addr),
        .probe_hit        (probe_hit),
        .probe_victim_hit (probe_victim_hit),
        .fill_we          (fill_we),
        .fill_addr        (fill_addr),
        .fill_data        (fill_data),
        .swap_we          (swap_we),
        .swap_addr        (swap_addr)
    );

endmodule

// File: test/icache_properties.sv
`timescale 1ns/10ps

module icache_properties
    import mem_bus_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input logic [31:0]  proc_addr,
    input logic         proc_valid,
    input bus_command_e mem_command,
    input logic [31:0]  mem_addr,
    input mem_tag_t     mem_response,
    input logic         mem_response_valid
);

    logic [31:0] prev_addr;
    logic        accept;
    logic        jump;

    assign accept = mem_response_valid && (mem_response != '0);
    // same jump rule as the fetch side, a jump flushes the pending command
    assign jump   = (proc_addr != prev_addr) && (proc_addr != prev_addr + 32'd4);

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_addr <= '0;
        end else begin
            prev_addr <= proc_addr;
        end
    end

    a_load_aligned: assert property (@(posedge clock) disable iff (reset)
        (mem_command == BUS_LOAD) |-> (mem_addr[2:0] == 3'b000))
        else $error("load address not block aligned");

    a_load_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command == BUS_LOAD && !accept && !jump)
            |=> (mem_command == BUS_LOAD && $stable(mem_addr)))
        else $error("load command dropped or changed before acceptance");

    a_valid_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(proc_valid))
        else $error("proc_valid unknown");

    a_no_idle_accept: assert property (@(posedge clock) disable iff (reset)
        accept |-> (mem_command == BUS_LOAD))
        else $error("response given with no load command");

endmodule

// File: test/icache_tb.sv
`timescale 1ns/10ps

module icache_tb
    import mem_bus_pkg::*;
();

    typedef logic [31:0] addr_q_t [$];

    localparam int TIMEOUT = 200;
    localparam logic [31:0] ADDR_A = 32'h0000_1040; // index 8, tag 0x10
    localparam logic [31:0] ADDR_B = 32'h0000_2040; // same index, tag 0x20
    localparam logic [31:0] ADDR_D = 32'h0000_3000;
    localparam logic [31:0] ADDR_E = 32'h0000_5080;

    logic         clock;
    logic         reset;
    logic [31:0]  proc_addr;
    mem_tag_t     mem_response;
    logic         mem_response_valid;
    mem_tag_t     mem_tag;
    logic [63:0]  mem_data;
    logic [31:0]  proc_data;
    logic         proc_valid;
    bus_command_e mem_command;
    logic [31:0]  mem_addr;

    int          mismatch_count;
    int          failure_count;
    logic [31:0] lfsr_state;
    logic [31:0] req_log [$];  // every accepted load address
    logic [31:0] dq_addr [$];  // data still owed by memory
    mem_tag_t    dq_tag [$];
    int          dq_due [$];
    int          cycle;
    int          resp_wait;
    int          accept_limit; // negative means unlimited
    mem_tag_t    next_tag;

    icache_top DUT (.*);

    bind icache_top icache_properties u_properties (
        .clock              (clock),
        .reset              (reset),
        .proc_addr          (proc_addr),
        .proc_valid         (proc_valid),
        .mem_command        (mem_command),
        .mem_addr           (mem_addr),
        .mem_response       (mem_response),
        .mem_response_valid (mem_response_valid)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    // line data is {block + 4, block}
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] block;
        block = addr & ~32'h7;
        return addr[2] ? block + 32'd4 : block;
    endfunction

    always @(negedge clock) begin : memory_model
        int idx;
        idx = -1;
        cycle++;
        for (int i = 0; i < dq_due.size(); i++) begin
            if (idx < 0 && dq_due[i] <= cycle) idx = i;
        end
        if (idx >= 0) begin
            mem_tag  = dq_tag[idx];
            mem_data = {dq_addr[idx] + 32'd4, dq_addr[idx]};
            dq_addr.delete(idx);
            dq_tag.delete(idx);
            dq_due.delete(idx);
        end else begin
            mem_tag = '0;
        end
        if (mem_response_valid) begin
            mem_response_valid = 1'b0; // taken on the last edge
            mem_response       = '0;
        end else if (mem_command == BUS_LOAD && accept_limit != 0) begin
            if (resp_wait == 0) resp_wait = draw_bits(2) % 3 + 1;
            resp_wait--;
            if (resp_wait == 0) begin
                mem_response_valid = 1'b1;
                mem_response       = next_tag;
                req_log.push_back(mem_addr);
                dq_addr.push_back(mem_addr);
                dq_tag.push_back(next_tag);
                dq_due.push_back(cycle + 2 + draw_bits(2));
                next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                if (accept_limit > 0) accept_limit--;
            end
        end else begin
            resp_wait = 0;
        end
    end

    task automatic word_compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic command_compare(input string name, input bus_command_e got,
                                   input bus_command_e exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic addr_list_compare(input string name, input addr_q_t got, input addr_q_t exp);
        if (got.size() != exp.size()) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s length got %0d expected %0d",
                     $time, name, got.size(), exp.size());
        end else begin
            foreach (got[i]) word_compare($sformatf("%s[%0d]", name, i), got[i], exp[i]);
        end
    endtask

    task automatic fetch_at(input logic [31:0] addr);
        @(negedge clock);
        proc_addr = addr;
        #2;
    endtask

    task automatic hold_until_hit(input string what);
        for (int i = 0; i < TIMEOUT; i++) begin
            if (proc_valid === 1'b1) return;
            @(negedge clock);
            #2;
        end
        failure_count++;
        $display("Timeout: no hit for %s after %0d cycles", what, TIMEOUT);
    endtask

    task automatic await_requests(input int count);
        for (int i = 0; i < TIMEOUT; i++) begin
            if (req_log.size() >= count) return;
            @(negedge clock);
            #2;
        end
        failure_count++;
        $display("Timeout: only %0d of %0d memory requests seen", req_log.size(), count);
    endtask

    task automatic reset_defaults();
        @(negedge clock);
        reset = 1'b0;
        // every edge sees a jump, so nothing is prefetched yet
        for (int i = 0; i < 4; i++) begin
            if (i > 0) @(negedge clock);
            proc_addr = 32'h0000_0100 + 32'(i) * 32'h0000_1234;
            #2;
            command_compare("mem_command", mem_command, BUS_NONE);
            word_compare("proc_valid", {31'b0, proc_valid}, 32'd0);
        end
    endtask

    task automatic cold_miss_sequential();
        addr_q_t exp;
        req_log.delete();
        fetch_at(ADDR_A);
        hold_until_hit("cold block A");
        word_compare("proc_data", proc_data, expected_word(ADDR_A));
        await_requests(8);
        for (int i = 0; i < 8; i++) exp.push_back(ADDR_A + 32'(8 * i));
        addr_list_compare("request list", req_log, exp);
        for (int i = 1; i < 8; i++) begin
            fetch_at(ADDR_A + 32'(4 * i));
            hold_until_hit("sequential word");
            word_compare("proc_data", proc_data, expected_word(ADDR_A + 32'(4 * i)));
        end
        // last word sits in block A + 3, so the window ends at block A + 10
        await_requests(11);
        repeat (10) @(negedge clock);
        #2;
        exp.delete();
        for (int i = 0; i < 11; i++) exp.push_back(ADDR_A + 32'(8 * i));
        addr_list_compare("request list after stepping", req_log, exp);
    endtask

    task automatic upper_lower_select();
        fetch_at(ADDR_A | 32'h4);
        hold_until_hit("upper word");
        word_compare("proc_data", proc_data, ADDR_A + 32'd4);
        fetch_at(ADDR_A);
        hold_until_hit("lower word");
        word_compare("proc_data", proc_data, ADDR_A);
    endtask

    task automatic victim_recovery();
        accept_limit = 1; // only B itself is served, so A is the one eviction
        fetch_at(ADDR_B);
        hold_until_hit("block B");
        word_compare("proc_data", proc_data, expected_word(ADDR_B));
        req_log.delete();
        fetch_at(ADDR_A);
        word_compare("proc_valid", {31'b0, proc_valid}, 32'd1);
        word_compare("proc_data", proc_data, ADDR_A);
        accept_limit = -1;
        repeat (20) @(negedge clock);
        #2;
        foreach (req_log[i]) begin
            if (req_log[i] == ADDR_A) begin
                failure_count++;
                $display("Block %h was requested from memory though it sat in the victim buffer",
                         ADDR_A);
            end
        end
    endtask

    task automatic redirect_flush();
        addr_q_t old_blocks;
        req_log.delete();
        fetch_at(ADDR_D);
        await_requests(1);
        fetch_at(ADDR_E); // data for D is still owed
        @(negedge clock);
        #2;
        old_blocks = req_log;
        req_log.delete();
        hold_until_hit("block E");
        word_compare("proc_data", proc_data, expected_word(ADDR_E));
        if (req_log.size() == 0) begin
            failure_count++;
            $display("No memory request seen after the jump");
        end else begin
            word_compare("first request after jump", req_log[0], ADDR_E);
        end
        repeat (12) @(negedge clock); // let the stale data drain
        if (old_blocks.size() == 0) begin
            failure_count++;
            $display("No request was outstanding at the jump");
        end
        foreach (old_blocks[i]) begin
            fetch_at(old_blocks[i]);
            word_compare("proc_valid", {31'b0, proc_valid}, 32'd0);
        end
    endtask

    initial begin
        reset              = 1'b1;
        proc_addr          = '0;
        mem_response       = '0;
        mem_response_valid = 1'b0;
        mem_tag            = '0;
        mem_data           = '0;
        mismatch_count     = 0;
        failure_count      = 0;
        lfsr_state         = 32'h7e0a_40b1;
        cycle              = 0;
        resp_wait          = 0;
        accept_limit       = -1;
        next_tag           = 4'd1;
        repeat (5) @(posedge clock);
        reset_defaults();
        cold_miss_sequential();
        upper_lower_select();
        victim_recovery();
        redirect_flush();
        $display("Summary: %0d mismatches, %0d other errors", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #400000;
        $display("Simulation ran out of time before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/icache_addr_pkg.sv
hw/mem_bus_pkg.sv
hw/miss_slot_if.sv
hw/prefetch_ctrl.sv
hw/miss_slot.sv
hw/mem_port.sv
hw/icache_store.sv
hw/icache_top.sv
test/icache_properties.sv
test/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module icache_tb \
    -o icache_sim

# the simulator status is not trusted, the log decides
./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
exit 1
